// ==== verilog/salsa_pkg.sv ====
package salsa_pkg;

	// One salsa20 word as the hash core sees it, already little-endian
	typedef logic [31:0] word_t;

	// A 512-bit salsa block held as sixteen words
	// Word 0 sits in bits 31:0, so indexing matches the usual x[0..15] notation
	typedef word_t [15:0] salsa_state_t;

	// Salsa20/8 runs eight rounds, which is four column+row double rounds
	localparam int salsa_double_rounds = 4;

endpackage

// ==== verilog/romix_pkg.sv ====
package romix_pkg;

	import salsa_pkg::*;

	localparam int block_bits = 1024; // Full scrypt block, r = 1

	// The same 1024 bits are seen either as 32 words or as the two BlockMix halves
	// Word view is used for byte swapping and for the index taken from word 16
	typedef union packed {
		word_t [31:0] w;
		struct packed {
			salsa_state_t x1; // Words 16..31
			salsa_state_t x0; // Words 0..15
		} half;
	} scrypt_block_t;

	// Controller states, one pass through each per hash
	typedef enum logic [2:0] {
		state_idle,
		state_load,   // Pull the block out of the shift register
		state_write,  // Fill the scratchpad
		state_mix,    // Read back at data-dependent addresses
		state_finish  // Hand the result back to the serial port
	} romix_state_e;

endpackage

// ==== verilog/scratch_if.sv ====
interface scratch_if
	import romix_pkg::*;
#(
	parameter int scratch_depth = 1024
);

	localparam int scratch_addr_bits = $clog2(scratch_depth);

	logic [scratch_addr_bits-1:0] addr; // Shared read/write address
	scrypt_block_t wdata;
	logic wren;
	scrypt_block_t rdata; // Entry at last cycle's addr

	// Controller owns the address and write side
	modport ctrl (output addr, output wdata, output wren, input rdata);

	// Memory answers with registered read data
	modport ram (input addr, input wdata, input wren, output rdata);

endinterface

// ==== verilog/serial_port.sv ====
module serial_port
	import salsa_pkg::*, romix_pkg::*;
(
	input  logic          hash_clk,
	input  logic          reset,
	input  logic          din,
	input  logic          shift,
	input  logic          busy,
	input  logic          load_result,
	input  scrypt_block_t block_out,
	output logic          dout,
	output scrypt_block_t block_in
);

	logic [block_bits-1:0] shift_reg; // Serial order, first bit in ends up at the top

	// Host sends big-endian words, salsa wants little-endian
	function automatic word_t swap_bytes(word_t v);
		return {v[7:0], v[15:8], v[23:16], v[31:24]};
	endfunction

	// Block as the controller sees it, valid at all times
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			block_in.w[i] = swap_bytes(shift_reg[32*i +: 32]);
	end

	assign dout = shift_reg[block_bits-1]; // Oldest bit leaves first

	always_ff @(posedge hash_clk)
	begin
		if (reset)
			shift_reg <= '0;
		else if (shift)
			shift_reg <= {shift_reg[block_bits-2:0], din}; // Result goes out as new data comes in
		else if (load_result)
		begin
			// Same swap in reverse so the host reads the result in its own byte order
			for (int i = 0; i < 32; i++)
				shift_reg[32*i +: 32] <= swap_bytes(block_out.w[i]);
		end
	end

	// The engine only owns the block while busy, the host has to keep its hands off
	assert property (@(posedge hash_clk) disable iff (reset) busy |-> !shift)
		else $error("shift asserted while the engine is busy");

endmodule

// ==== verilog/scratchpad_ram.sv ====
module scratchpad_ram
	import romix_pkg::*;
#(
	parameter int scratch_depth = 1024
)
(
	input logic  hash_clk,
	scratch_if.ram mem
);

	// One complete block per entry
	logic [block_bits-1:0] store [scratch_depth];

	// Single port, read-before-write, output register so it infers block RAM
	always_ff @(posedge hash_clk)
	begin
		if (mem.wren)
			store[mem.addr] <= mem.wdata;
		mem.rdata <= store[mem.addr]; // One cycle of read latency
	end

endmodule

// ==== verilog/salsa_core.sv ====
module salsa_core
	import salsa_pkg::*;
(
	input  logic         hash_clk,
	input  logic         reset,
	input  logic         go,
	input  salsa_state_t salsa_in,
	output salsa_state_t salsa_out,
	output logic         done
);

	localparam int round_bits = $clog2(salsa_double_rounds);

	salsa_state_t state; // Working copy, one double round further each clock
	salsa_state_t saved; // Input kept for the final feed-forward add
	salsa_state_t round_out;
	logic [round_bits-1:0] rounds_left;
	logic running;
	logic last_round;

	function automatic word_t rotl(word_t v, int n);
		return (v << n) | (v >> (32 - n));
	endfunction

	// Standard salsa quarter round, arguments in the order the spec rotates them
	function automatic logic [127:0] quarter(word_t a, word_t b, word_t c, word_t d);
		word_t na;
		word_t nb;
		word_t nc;
		word_t nd;
		nb = b ^ rotl(a + d, 7);
		nc = c ^ rotl(nb + a, 9);
		nd = d ^ rotl(nc + nb, 13);
		na = a ^ rotl(nd + nc, 18);
		return {na, nb, nc, nd};
	endfunction

	function automatic salsa_state_t double_round(salsa_state_t s_in);
		salsa_state_t s;
		s = s_in;
		// Column round
		{s[0], s[4], s[8], s[12]} = quarter(s[0], s[4], s[8], s[12]);
		{s[5], s[9], s[13], s[1]} = quarter(s[5], s[9], s[13], s[1]);
		{s[10], s[14], s[2], s[6]} = quarter(s[10], s[14], s[2], s[6]);
		{s[15], s[3], s[7], s[11]} = quarter(s[15], s[3], s[7], s[11]);
		// Row round
		{s[0], s[1], s[2], s[3]} = quarter(s[0], s[1], s[2], s[3]);
		{s[5], s[6], s[7], s[4]} = quarter(s[5], s[6], s[7], s[4]);
		{s[10], s[11], s[8], s[9]} = quarter(s[10], s[11], s[8], s[9]);
		{s[15], s[12], s[13], s[14]} = quarter(s[15], s[12], s[13], s[14]);
		return s;
	endfunction

	// First round is applied on the very edge that latches the input
	assign round_out = double_round(go ? salsa_in : state);
	assign last_round = running && (rounds_left == 1);

	always_ff @(posedge hash_clk)
	begin
		if (go || running)
			state <= round_out;
		if (go)
			saved <= salsa_in;
		if (last_round)
		begin
			for (int i = 0; i < 16; i++)
				salsa_out[i] <= round_out[i] + saved[i]; // Feed-forward, word by word
		end
	end

	always_ff @(posedge hash_clk)
	begin
		if (reset)
		begin
			running <= 1'b0;
			rounds_left <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= last_round; // Lands 4 cycles after go
			if (go)
			begin
				running <= 1'b1;
				rounds_left <= round_bits'(salsa_double_rounds - 1);
			end
			else if (running)
			begin
				rounds_left <= rounds_left - 1'b1;
				if (rounds_left == 1)
					running <= 1'b0; // Free again in the done cycle
			end
		end
	end

	// Controller chains the second half on done, never earlier
	assert property (@(posedge hash_clk) disable iff (reset) go |-> !running)
		else $error("salsa go while a computation is in flight");

endmodule

// ==== verilog/romix_ctrl.sv ====
module romix_ctrl
	import salsa_pkg::*, romix_pkg::*;
#(
	parameter int scratch_depth = 1024
)
(
	input  logic          hash_clk,
	input  logic          reset,
	input  logic          start,
	input  scrypt_block_t block_in,
	scratch_if.ctrl       mem,
	output salsa_state_t  salsa_in,
	output logic          go,
	input  salsa_state_t  salsa_out,
	input  logic          done,
	output scrypt_block_t block_out,
	output logic          load_result,
	output logic          busy,
	output logic          result
);

	localparam int scratch_addr_bits = $clog2(scratch_depth);
	localparam logic [scratch_addr_bits-1:0] last_index = scratch_addr_bits'(scratch_depth - 1);

	romix_state_e state;
	scrypt_block_t x; // The running X of ROMix
	scrypt_block_t x_mixed; // X with the scratchpad entry folded in, on the read cycle only
	logic [scratch_addr_bits-1:0] iter; // Write address in the first phase, loop count in both
	logic [3:0] step; // Cycle within one iteration, only 0 and 1 matter for control
	logic second_half; // First salsa of BlockMix has already landed in x0
	logic read_xor;

	// Mix step 1 is when rdata holds entry j requested in step 0
	assign read_xor = (state == state_mix) && (step == 4'd1);
	assign x_mixed = read_xor ? (x ^ mem.rdata) : x;

	// Write phase stores X as it stands at the top of the iteration
	assign mem.wren = (state == state_write) && (step == 4'd0);
	assign mem.wdata = x;
	assign mem.addr = (state == state_mix) ? x.w[16][scratch_addr_bits-1:0] : iter; // j = Integerify(X)

	// Start the first salsa right away and chain the second one on the done cycle
	assign go = mem.wren || read_xor || (done && !second_half);
	assign salsa_in = done ? (x.half.x1 ^ salsa_out) : (x_mixed.half.x0 ^ x_mixed.half.x1);

	assign block_out = x;
	assign load_result = (state == state_finish); // Serial port captures on the same edge result rises

	// X comes from the serial port in the load state and then follows the read XOR and each BlockMix half
	always_ff @(posedge hash_clk)
	begin
		if (state == state_load)
			x <= block_in;
		else if (read_xor)
			x <= x_mixed;
		else if (done)
		begin
			if (second_half)
				x.half.x1 <= salsa_out;
			else
				x.half.x0 <= salsa_out;
		end
	end

	always_ff @(posedge hash_clk)
	begin
		if (reset)
		begin
			state <= state_idle;
			busy <= 1'b0;
			result <= 1'b0;
			iter <= '0;
			step <= '0;
			second_half <= 1'b0;
		end
		else
		begin
			result <= (state == state_finish); // Single-cycle pulse
			case (state)
				state_idle:
					if (start)
						state <= state_load; // Start only counts here, so it is ignored while busy
				state_load:
				begin
					busy <= 1'b1;
					iter <= '0;
					step <= '0;
					second_half <= 1'b0;
					state <= state_write;
				end
				state_write, state_mix:
				begin
					step <= step + 1'b1;
					if (done)
					begin
						second_half <= ~second_half;
						if (second_half)
						begin
							// BlockMix finished, next iteration
							step <= '0;
							iter <= iter + 1'b1; // Wraps to zero for the mix phase
							if (iter == last_index)
								state <= (state == state_write) ? state_mix : state_finish;
						end
					end
				end
				state_finish:
				begin
					busy <= 1'b0;
					state <= state_idle;
				end
				default:
					state <= state_idle;
			endcase
		end
	end

	// X takes either the scratchpad XOR or a salsa result in one cycle, never both
	assert property (@(posedge hash_clk) disable iff (reset) read_xor |-> !done)
		else $error("salsa result arrived on the scratchpad read cycle");

endmodule

// ==== verilog/scrypt_romix_core.sv ====
module scrypt_romix_core
	import salsa_pkg::*, romix_pkg::*;
#(
	parameter int scratch_depth = 1024
)
(
	input  logic hash_clk,
	input  logic reset,
	input  logic din,
	input  logic shift,
	input  logic start,
	output logic dout,
	output logic busy,
	output logic result
);

	scrypt_block_t block_in; // Little-endian view of the shift register
	scrypt_block_t block_out;
	logic load_result;
	salsa_state_t salsa_in;
	salsa_state_t salsa_out;
	logic go;
	logic done;

	scratch_if #(.scratch_depth(scratch_depth)) scratch ();

	serial_port i_serial_port (
		.hash_clk    (hash_clk),
		.reset       (reset),
		.din         (din),
		.shift       (shift),
		.busy        (busy),
		.load_result (load_result),
		.block_out   (block_out),
		.dout        (dout),
		.block_in    (block_in)
	);

	scratchpad_ram #(.scratch_depth(scratch_depth)) i_scratchpad_ram (
		.hash_clk (hash_clk),
		.mem      (scratch.ram)
	);

	salsa_core i_salsa_core (
		.hash_clk  (hash_clk),
		.reset     (reset),
		.go        (go),
		.salsa_in  (salsa_in),
		.salsa_out (salsa_out),
		.done      (done)
	);

	romix_ctrl #(.scratch_depth(scratch_depth)) i_romix_ctrl (
		.hash_clk    (hash_clk),
		.reset       (reset),
		.start       (start),
		.block_in    (block_in),
		.mem         (scratch.ctrl),
		.salsa_in    (salsa_in),
		.go          (go),
		.salsa_out   (salsa_out),
		.done        (done),
		.block_out   (block_out),
		.load_result (load_result),
		.busy        (busy),
		.result      (result)
	);

endmodule

// ==== verif/tb_scrypt_romix_core.sv ====
module tb_scrypt_romix_core
	import salsa_pkg::*, romix_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int ref_depth = 16; // Small scratchpad keeps each hash around 300 cycles
	localparam int result_latency = 19 * ref_depth + 2; // Edges from start sample to result
	localparam int timeout_cycles = 6 * (result_latency + 1100);

	// Quarter round word order (a, b, c, d), four columns then four rows
	localparam int quad_order [8][4] = '{
		'{0, 4, 8, 12}, '{5, 9, 13, 1}, '{10, 14, 2, 6}, '{15, 3, 7, 11},
		'{0, 1, 2, 3}, '{5, 6, 7, 4}, '{10, 11, 8, 9}, '{15, 12, 13, 14}
	};

	logic hash_clk = 1'b0;
	logic reset;
	logic din;
	logic shift;
	logic start;
	logic dout;
	logic busy;
	logic result;

	int seed = 59578;
	int cycle = 0; // Rising edges since time zero
	int start_cycle; // Edge count at the edge that sampled start
	logic run_pending = 1'b0; // A hash is in flight and its strobes are being tracked
	scrypt_block_t expected_result; // Serial-order result of the block last started
	event run_finished;

	scrypt_romix_core #(.scratch_depth(ref_depth)) i_scrypt_romix_core (
		.hash_clk (hash_clk),
		.reset    (reset),
		.din      (din),
		.shift    (shift),
		.start    (start),
		.dout     (dout),
		.busy     (busy),
		.result   (result)
	);

	always #2 hash_clk = ~hash_clk;

	function automatic word_t rol32(word_t v, int n);
		return (v << n) | (v >> (32 - n));
	endfunction

	// Serial words arrive big-endian, salsa works on little-endian words
	function automatic word_t byte_swap_word(word_t v);
		word_t r;
		for (int k = 0; k < 4; k++)
			r[8*k +: 8] = v[8*(3-k) +: 8];
		return r;
	endfunction

	function automatic salsa_state_t salsa20_8(salsa_state_t b_in);
		word_t x [16];
		salsa_state_t b_out;
		int ia;
		int ib;
		int ic;
		int id;
		for (int i = 0; i < 16; i++)
			x[i] = b_in[i];
		for (int r = 0; r < 8; r += 2) // Eight rounds, taken as column and row pairs
		begin
			for (int q = 0; q < 8; q++)
			begin
				ia = quad_order[q][0];
				ib = quad_order[q][1];
				ic = quad_order[q][2];
				id = quad_order[q][3];
				x[ib] ^= rol32(x[ia] + x[id], 7);
				x[ic] ^= rol32(x[ib] + x[ia], 9);
				x[id] ^= rol32(x[ic] + x[ib], 13);
				x[ia] ^= rol32(x[id] + x[ic], 18);
			end
		end
		for (int i = 0; i < 16; i++)
			b_out[i] = x[i] + b_in[i]; // Feed-forward of the original input
		return b_out;
	endfunction

	// Second half uses the freshly updated first half
	function automatic scrypt_block_t block_mix(scrypt_block_t b_in);
		scrypt_block_t b;
		b = b_in;
		b.half.x0 = salsa20_8(b.half.x0 ^ b.half.x1);
		b.half.x1 = salsa20_8(b.half.x1 ^ b.half.x0);
		return b;
	endfunction

	// Full ROMix from serial order back to serial order
	function automatic scrypt_block_t romix_ref(scrypt_block_t serial_in);
		scrypt_block_t x;
		scrypt_block_t v [ref_depth];
		scrypt_block_t serial_out;
		int j;
		for (int i = 0; i < 32; i++)
			x.w[i] = byte_swap_word(serial_in.w[i]);
		for (int i = 0; i < ref_depth; i++)
		begin
			v[i] = x;
			x = block_mix(x);
		end
		for (int i = 0; i < ref_depth; i++)
		begin
			j = int'(x.w[16] % ref_depth); // Integerify takes word 16 modulo the depth
			x = block_mix(x ^ v[j]);
		end
		for (int i = 0; i < 32; i++)
			serial_out.w[i] = byte_swap_word(x.w[i]);
		return serial_out;
	endfunction

	task automatic stop_with_failure();
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_bit(string name, logic expected, logic actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %b got %b", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic check_block(string name, scrypt_block_t expected, scrypt_block_t actual);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t %s expected %h got %h", $time, name, expected, actual);
			stop_with_failure();
		end
	endtask

	task automatic make_random_block(output scrypt_block_t blk);
		for (int i = 0; i < 32; i++)
			blk.w[i] = $random(seed);
	endtask

	// Entered on a falling edge; the old register contents come out on dout meanwhile
	task automatic shift_block(input scrypt_block_t serial_in, output scrypt_block_t serial_out);
		logic [block_bits-1:0] bits_in;
		logic [block_bits-1:0] captured;
		bits_in = serial_in;
		for (int i = block_bits - 1; i >= 0; i--)
		begin
			captured[i] = dout; // Top bit of the register leaves first
			din = bits_in[i];
			shift = 1'b1;
			@(negedge hash_clk);
		end
		shift = 1'b0;
		din = 1'b0;
		serial_out = captured;
	endtask

	// Starts a hash on the block already in the shift register and waits for its result
	task automatic run_block(scrypt_block_t loaded);
		expected_result = romix_ref(loaded);
		start = 1'b1;
		@(negedge hash_clk);
		start = 1'b0;
		start_cycle = cycle;
		run_pending = 1'b1;
		@(run_finished);
		run_pending = 1'b0;
	endtask

	always @(posedge hash_clk)
	begin
		cycle <= cycle + 1;
		if (cycle >= timeout_cycles)
		begin
			$display("Timeout after %0d clock cycles, the engine never finished", cycle);
			stop_with_failure();
		end
	end

	// Strobe checker, sampled on the falling edge where outputs are settled
	always @(negedge hash_clk)
	begin
		int elapsed;
		elapsed = cycle - start_cycle;
		if (run_pending)
		begin
			check_bit("result", elapsed == result_latency, result);
			check_bit("busy", (elapsed >= 1) && (elapsed < result_latency), busy);
			if (result)
				-> run_finished;
		end
		else if (!reset)
		begin
			check_bit("result", 1'b0, result); // No strobe without a started hash
			check_bit("busy", 1'b0, busy);
		end
	end

	initial
	begin
		scrypt_block_t zero_block;
		scrypt_block_t loaded_block;
		scrypt_block_t next_block;
		scrypt_block_t unloaded;
		reset = 1'b1;
		din = 1'b0;
		shift = 1'b0;
		start = 1'b0;
		zero_block = '0;
		repeat (2) @(negedge hash_clk);
		reset = 1'b0;
		check_bit("busy", 1'b0, busy);
		check_bit("result", 1'b0, result);
		check_bit("dout", 1'b0, dout);

		// Cleared register unloads as zeros while the zero block goes in
		shift_block(zero_block, unloaded);
		check_block("dout stream", zero_block, unloaded);
		loaded_block = zero_block;

		// Each unload brings the next random block in at the same time
		repeat (3)
		begin
			run_block(loaded_block);
			make_random_block(next_block);
			shift_block(next_block, unloaded);
			check_block("dout stream", expected_result, unloaded);
			loaded_block = next_block;
		end

		repeat (100)
		begin
			@(negedge hash_clk);
			check_bit("busy", 1'b0, busy);
			check_bit("result", 1'b0, result);
		end

		run_block(loaded_block);
		shift_block(zero_block, unloaded);
		check_block("dout stream", expected_result, unloaded);

		$display("Simulation PASSED");
		$finish;
	end

endmodule

// ==== scrypt_romix_core.f ====
verilog/salsa_pkg.sv
verilog/romix_pkg.sv
verilog/scratch_if.sv
verilog/serial_port.sv
verilog/scratchpad_ram.sv
verilog/salsa_core.sv
verilog/romix_ctrl.sv
verilog/scrypt_romix_core.sv
verif/tb_scrypt_romix_core.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Builds the ROMix testbench with Verilator, runs it and reads the verdict from the log

cd "$(dirname "$0")" || exit 1

log_file=sim.log

verilator --binary --timing --assert --top-module tb_scrypt_romix_core -f scrypt_romix_core.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/Vtb_scrypt_romix_core > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "Simulator exited with status $sim_status"
	exit 1
fi

if grep -q "^Simulation PASSED$" "$log_file"; then
	exit 0
fi
exit 1
